//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sm83_core
FILELIST  ?= sm83_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sm83_addr_unit.sv
`timescale 1ns/1ps

module sm83_addr_unit (
    input  logic [sm83_pkg::ADDR_W-1:0] ab,
    input  sm83_pkg::ab_mask_t          ab_mask,
    input  sm83_pkg::idu_mode_t         idu_mode,
    input  logic                        alu_c,
    input  logic                        e_sign,
    output logic [sm83_pkg::ADDR_W-1:0] addr,
    output logic [sm83_pkg::ADDR_W-1:0] idu_res
);
    import sm83_pkg::*;

    logic [DATA_W-1:0] hi_adj;

    always_comb begin
        case (ab_mask)
            AB_AND_FF00: addr = {ab[ADDR_W-1:DATA_W], {DATA_W{1'b0}}};
            AB_ZERO:     addr = '0;
            default:     addr = ab;
        endcase
    end

    // High byte fix-up after PCL + e
    always_comb begin
        if (alu_c && !e_sign) begin
            hi_adj = addr[ADDR_W-1:DATA_W] + DATA_W'(1);
        end else if (!alu_c && e_sign) begin
            hi_adj = addr[ADDR_W-1:DATA_W] - DATA_W'(1);
        end else begin
            hi_adj = addr[ADDR_W-1:DATA_W];
        end
    end

    always_comb begin
        case (idu_mode)
            INC:     idu_res = addr + ADDR_W'(1);
            DEC:     idu_res = addr - ADDR_W'(1);
            ADJ:     idu_res = {hi_adj, addr[DATA_W-1:0]};
            default: idu_res = addr;
        endcase
    end

endmodule

//--- sm83_alu.sv
`timescale 1ns/1ps

module sm83_alu (
    input  logic                        clk,
    input  logic                        rst,
    input  sm83_pkg::alu_op_t           alu_op,
    input  sm83_pkg::acc_sel_t          acc_sel,
    input  sm83_pkg::arg_sel_t          arg_sel,
    input  logic                        flag_we,
    input  logic [sm83_pkg::DATA_W-1:0] a_val,
    input  logic [sm83_pkg::DATA_W-1:0] db,
    input  logic [sm83_pkg::DATA_W-1:0] pcl_val,
    input  logic                        jr_mode,
    output logic [sm83_pkg::DATA_W-1:0] alu_res,
    output logic                        alu_c,
    output sm83_pkg::flags_t            flags
);
    import sm83_pkg::*;

    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] arg;
    logic [DATA_W-1:0] arg_x;
    logic              sub;
    logic              logic_op;
    logic              cin;
    logic [4:0]        lo_sum;
    logic [4:0]        hi_sum;
    flags_t            f_next;

    always_comb begin
        acc      = jr_mode ? pcl_val : ((acc_sel == ACC_DB) ? db : a_val);
        arg      = (arg_sel == ARG_ONE) ? DATA_W'(1) : db;
        sub      = alu_op inside {ALU_SUB, ALU_SBC, ALU_CP};
        logic_op = alu_op inside {ALU_AND, ALU_XOR, ALU_OR};
        case (alu_op)
            ALU_ADC:         cin = flags.c;
            ALU_SBC:         cin = !flags.c;   // Borrow in
            ALU_SUB, ALU_CP: cin = 1'b1;
            default:         cin = 1'b0;
        endcase
        arg_x  = sub ? ~arg : arg;
        lo_sum = {1'b0, acc[3:0]} + {1'b0, arg_x[3:0]} + {4'd0, cin};
        hi_sum = {1'b0, acc[7:4]} + {1'b0, arg_x[7:4]} + {4'd0, lo_sum[4]};
        alu_c  = hi_sum[4] ^ sub;               // Carry, or borrow on subtract
        case (alu_op)
            ALU_AND: alu_res = acc & arg;
            ALU_XOR: alu_res = acc ^ arg;
            ALU_OR:  alu_res = acc | arg;
            default: alu_res = {hi_sum[3:0], lo_sum[3:0]};
        endcase
        f_next.z = (alu_res == '0);
        f_next.n = sub && !logic_op;
        f_next.h = (lo_sum[4] ^ sub) && !logic_op;
        f_next.c = alu_c && !logic_op;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            flags <= '0;
        end else if (flag_we) begin
            flags <= f_next;
        end
    end

endmodule

//--- sm83_control.sv
`timescale 1ns/1ps

module sm83_control (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [sm83_pkg::DATA_W-1:0] d_in,
    input  sm83_pkg::flags_t            flags,
    output sm83_pkg::reg8_t             s_db,
    output sm83_pkg::reg8_t             t_db,
    output sm83_pkg::reg16_t            s_ab,
    output sm83_pkg::ab_mask_t          ab_mask,
    output sm83_pkg::acc_sel_t          acc_sel,
    output sm83_pkg::arg_sel_t          arg_sel,
    output sm83_pkg::alu_op_t           alu_op,
    output logic                        alu_wb,
    output logic                        flag_we,
    output sm83_pkg::idu_mode_t         idu_mode,
    output logic                        wr_pc,
    output sm83_pkg::rr_wb_t            rr_wb,
    output sm83_pkg::reg16_t            t_rr
);
    import sm83_pkg::*;

    localparam logic [2:0] SKIP_STEP = 3'd3;   // JR cc,e not taken

    logic [DATA_W-1:0] ir;
    logic [2:0]        step;
    op_class_t         op_class;
    reg8_t             r_dst;
    reg8_t             r_src;
    cond_t             cond;
    logic              cond_met;
    alu_op_t           alu_field;
    logic              done;        // Last step, fetch next opcode
    logic              is_cond;     // Branch on cond in this step
    logic              imm;         // Read operand at PC and bump PC

    // Register field of the opcode, slot 6 is (HL)
    function automatic reg8_t decode_r8(input logic [2:0] field);
        case (field)
            3'd0: return B;
            3'd1: return C;
            3'd2: return D;
            3'd3: return E;
            3'd4: return H;
            3'd5: return L;
            3'd7: return A;
            default: return NONE;
        endcase
    endfunction

    assign r_dst     = decode_r8(ir[5:3]);
    assign r_src     = decode_r8(ir[2:0]);
    assign cond      = cond_t'(ir[4:3]);
    assign alu_field = alu_op_t'(ir[5:3]);

    always_comb begin
        casez (ir)
            8'h00:       op_class = NOP;
            8'h18:       op_class = JR_E;
            8'hC3:       op_class = JP_NN;
            8'b001??000: op_class = JR_CC_E;
            8'b00???110: op_class = (r_dst == NONE) ? ILLEGAL : LD_R_N;
            8'b00???10?: op_class = (r_dst == NONE) ? ILLEGAL : INCDEC_R;
            8'b01110???: op_class = (r_src == NONE) ? ILLEGAL : LD_HL_R;
            8'b01??????: op_class = (r_src == NONE) ? ILLEGAL : LD_R_R;
            8'b10??????: op_class = (r_src == NONE) ? ILLEGAL : ALU_A_R;
            8'b11???110: op_class = ALU_A_N;
            default:     op_class = ILLEGAL;
        endcase
    end

    always_comb begin
        case (cond)
            COND_NZ: cond_met = !flags.z;
            COND_Z:  cond_met = flags.z;
            COND_NC: cond_met = !flags.c;
            default: cond_met = flags.c;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ir   <= '0;                 // NOP opcode
            step <= 3'd0;
        end else if (done) begin
            ir   <= d_in;
            step <= 3'd0;
        end else if (is_cond && !cond_met) begin
            step <= SKIP_STEP;
        end else begin
            step <= step + 3'd1;
        end
    end

    // Microcode
    always_comb begin
        done     = 1'b0;
        is_cond  = 1'b0;
        imm      = 1'b0;
        s_db     = NONE;
        t_db     = NONE;
        s_ab     = PC;
        ab_mask  = AB_NO_MASK;
        acc_sel  = ACC_A;
        arg_sel  = ARG_DB;
        alu_op   = alu_field;
        alu_wb   = 1'b0;
        flag_we  = 1'b0;
        idu_mode = HOLD;
        wr_pc    = 1'b0;
        rr_wb    = RR_WB_NONE;
        t_rr     = WZ;
        case (op_class)
            LD_R_R: begin
                done = 1'b1;
                s_db = r_src;
                t_db = r_dst;
            end
            LD_HL_R: begin
                if (step == 3'd0) begin
                    s_ab = HL;
                    s_db = r_src;
                    t_db = MEM;
                end else begin
                    done = 1'b1;
                end
            end
            LD_R_N: begin
                if (step == 3'd0) begin
                    imm  = 1'b1;
                    t_db = Z;
                end else begin
                    done = 1'b1;
                    s_db = Z;
                    t_db = r_dst;
                end
            end
            ALU_A_R, ALU_A_N: begin
                if (op_class == ALU_A_N && step == 3'd0) begin
                    imm  = 1'b1;
                    t_db = Z;
                end else begin
                    done    = 1'b1;
                    s_db    = (op_class == ALU_A_N) ? Z : r_src;
                    t_db    = (alu_field == ALU_CP) ? NONE : A;  // CP keeps A
                    alu_wb  = 1'b1;
                    flag_we = 1'b1;
                end
            end
            INCDEC_R: begin
                done    = 1'b1;
                s_db    = r_dst;
                t_db    = r_dst;
                acc_sel = ACC_DB;
                arg_sel = ARG_ONE;
                alu_op  = ir[0] ? ALU_SUB : ALU_ADD;
                alu_wb  = 1'b1;
                flag_we = 1'b1;
            end
            JP_NN: begin
                case (step)
                    3'd0: begin
                        imm  = 1'b1;
                        t_db = Z;
                    end
                    3'd1: begin
                        imm  = 1'b1;
                        t_db = W;
                    end
                    3'd2: begin
                        ab_mask = AB_ZERO;      // Idle bus cycle
                        rr_wb   = RR_WB_WZ;
                        t_rr    = PC;
                    end
                    default: done = 1'b1;
                endcase
            end
            JR_E, JR_CC_E: begin
                case (step)
                    3'd0: begin
                        imm     = 1'b1;
                        t_db    = Z;
                        is_cond = (op_class == JR_CC_E);
                    end
                    3'd1: begin
                        ab_mask  = AB_AND_FF00;     // IDU sees PCH only
                        idu_mode = ADJ;
                        s_db     = Z;
                        t_db     = Z;               // Z <- PCL + e
                        alu_op   = ALU_ADD;
                        alu_wb   = 1'b1;
                        rr_wb    = RR_WB_IDU;       // W <- adjusted PCH
                        t_rr     = WZ;
                    end
                    3'd2: begin
                        done = 1'b1;
                        s_ab = WZ;
                    end
                    default: done = 1'b1;
                endcase
            end
            default: done = 1'b1;       // NOP and unsupported opcodes
        endcase

        // Both the opcode fetch and the operand read step PC
        if (done || imm) begin
            idu_mode = INC;
            wr_pc    = 1'b1;
        end
        if (imm) begin
            s_db = MEM;
        end
    end

endmodule

//--- sm83_core.f
+incdir+.
sm83_pkg.sv
sm83_control.sv
sm83_regfile.sv
sm83_alu.sv
sm83_addr_unit.sv
sm83_core.sv
tb_sm83_core.sv

//--- sm83_core.sv
`timescale 1ns/1ps

module sm83_core #(
    parameter logic [sm83_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [sm83_pkg::DATA_W-1:0] d_in,
    output logic [sm83_pkg::ADDR_W-1:0] addr,
    output logic [sm83_pkg::DATA_W-1:0] d_out,
    output logic                        write
);
    import sm83_pkg::*;

    reg8_t             s_db;
    reg8_t             t_db;
    reg16_t            s_ab;
    reg16_t            t_rr;
    ab_mask_t          ab_mask;
    acc_sel_t          acc_sel;
    arg_sel_t          arg_sel;
    alu_op_t           alu_op;
    idu_mode_t         idu_mode;
    rr_wb_t            rr_wb;
    flags_t            flags;
    logic              alu_wb;
    logic              flag_we;
    logic              wr_pc;
    logic              alu_c;
    logic              jr_mode;
    logic [DATA_W-1:0] db;
    logic [DATA_W-1:0] alu_res;
    logic [DATA_W-1:0] a_val;
    logic [DATA_W-1:0] pcl_val;
    logic [ADDR_W-1:0] ab;
    logic [ADDR_W-1:0] bus_addr;
    logic [ADDR_W-1:0] idu_res;

    assign jr_mode = (idu_mode == ADJ);     // ALU adds e to PCL
    assign addr    = rst ? bus_addr : '0;
    assign write   = rst && (t_db == MEM);
    assign d_out   = db;

    sm83_control control_i (
        .clk(clk), .rst(rst), .d_in(d_in), .flags(flags),
        .s_db(s_db), .t_db(t_db), .s_ab(s_ab), .ab_mask(ab_mask),
        .acc_sel(acc_sel), .arg_sel(arg_sel), .alu_op(alu_op),
        .alu_wb(alu_wb), .flag_we(flag_we), .idu_mode(idu_mode),
        .wr_pc(wr_pc), .rr_wb(rr_wb), .t_rr(t_rr)
    );

    sm83_regfile #(.RESET_PC(RESET_PC)) regfile_i (
        .clk(clk), .rst(rst), .s_db(s_db), .t_db(t_db), .s_ab(s_ab),
        .wr_pc(wr_pc), .rr_wb(rr_wb), .t_rr(t_rr), .alu_wb(alu_wb),
        .d_in(d_in), .alu_res(alu_res), .idu_res(idu_res),
        .db(db), .ab(ab), .a_val(a_val), .pcl_val(pcl_val)
    );

    sm83_alu alu_i (
        .clk(clk), .rst(rst), .alu_op(alu_op), .acc_sel(acc_sel),
        .arg_sel(arg_sel), .flag_we(flag_we), .a_val(a_val), .db(db),
        .pcl_val(pcl_val), .jr_mode(jr_mode),
        .alu_res(alu_res), .alu_c(alu_c), .flags(flags)
    );

    sm83_addr_unit addr_unit_i (
        .ab(ab), .ab_mask(ab_mask), .idu_mode(idu_mode), .alu_c(alu_c),
        .e_sign(db[DATA_W-1]), .addr(bus_addr), .idu_res(idu_res)
    );

endmodule

//--- sm83_pkg.sv
package sm83_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // Byte registers, plus "no register" and the memory bus as pseudo-sources
    typedef enum logic [3:0] {
        NONE,
        Z, W,
        B, C, D, E, H, L,
        PCH, PCL,
        A,
        MEM
    } reg8_t;

    // Register pairs used on the address bus or as a 16-bit target
    typedef enum logic [2:0] {
        WZ, HL, PC
    } reg16_t;

    typedef enum logic [3:0] {
        NOP, LD_R_N, LD_R_R, LD_HL_R,
        ALU_A_R, ALU_A_N, INCDEC_R,
        JP_NN, JR_E, JR_CC_E,
        ILLEGAL                         // Executes as NOP
    } op_class_t;

    // Same order as opcode bits [5:3]
    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR, ALU_CP
    } alu_op_t;

    typedef enum logic [1:0] {
        COND_NZ, COND_Z, COND_NC, COND_C
    } cond_t;

    typedef enum logic [1:0] {
        AB_NO_MASK, AB_AND_FF00, AB_ZERO
    } ab_mask_t;

    typedef enum logic [1:0] {
        INC, DEC, ADJ, HOLD
    } idu_mode_t;

    typedef enum logic {
        ACC_A, ACC_DB
    } acc_sel_t;

    typedef enum logic {
        ARG_DB, ARG_ONE
    } arg_sel_t;

    typedef enum logic [1:0] {
        RR_WB_NONE, RR_WB_IDU, RR_WB_WZ
    } rr_wb_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

endpackage

//--- sm83_regfile.sv
`timescale 1ns/1ps

module sm83_regfile #(
    parameter logic [sm83_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  sm83_pkg::reg8_t             s_db,
    input  sm83_pkg::reg8_t             t_db,
    input  sm83_pkg::reg16_t            s_ab,
    input  logic                        wr_pc,
    input  sm83_pkg::rr_wb_t            rr_wb,
    input  sm83_pkg::reg16_t            t_rr,
    input  logic                        alu_wb,
    input  logic [sm83_pkg::DATA_W-1:0] d_in,
    input  logic [sm83_pkg::DATA_W-1:0] alu_res,
    input  logic [sm83_pkg::ADDR_W-1:0] idu_res,
    output logic [sm83_pkg::DATA_W-1:0] db,
    output logic [sm83_pkg::ADDR_W-1:0] ab,
    output logic [sm83_pkg::DATA_W-1:0] a_val,
    output logic [sm83_pkg::DATA_W-1:0] pcl_val
);
    import sm83_pkg::*;

    logic [DATA_W-1:0] rf [Z:A];
    logic [ADDR_W-1:0] wz;
    logic [ADDR_W-1:0] hl;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] rr_val;

    assign wz      = {rf[W], rf[Z]};
    assign hl      = {rf[H], rf[L]};
    assign pc      = {rf[PCH], rf[PCL]};
    assign a_val   = rf[A];
    assign pcl_val = rf[PCL];
    assign rr_val  = (rr_wb == RR_WB_WZ) ? wz : idu_res;

    always_comb begin
        case (s_db)
            MEM:     db = d_in;
            NONE:    db = '0;
            default: db = rf[s_db];
        endcase
    end

    always_comb begin
        case (s_ab)
            WZ:      ab = wz;
            HL:      ab = hl;
            default: ab = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = Z; i <= A; i++) begin
                rf[i] <= '0;
            end
            {rf[PCH], rf[PCL]} <= RESET_PC;
        end else begin
            if (wr_pc) begin
                {rf[PCH], rf[PCL]} <= idu_res;
            end
            if (rr_wb != RR_WB_NONE) begin
                case (t_rr)
                    WZ:      {rf[W], rf[Z]} <= rr_val;
                    HL:      {rf[H], rf[L]} <= rr_val;
                    default: {rf[PCH], rf[PCL]} <= rr_val;
                endcase
            end
            // Byte write comes last so it wins over a pair write to Z in JR
            if (t_db != NONE && t_db != MEM) begin
                rf[t_db] <= alu_wb ? alu_res : db;
            end
        end
    end

endmodule

//--- tb_sm83_model.svh
`ifndef TB_SM83_MODEL_SVH
`define TB_SM83_MODEL_SVH

// Result and flags as {res, z, n, h, c}
function automatic logic [11:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                          input logic [7:0] b, input logic cy);
    int         full;
    int         low;
    int         cin;
    logic [7:0] res;
    logic       n;
    logic       h;
    logic       c;
    cin = (op == 3'd1 || op == 3'd3) ? int'(cy) : 0;   // Carry only for ADC and SBC
    n   = 1'b0;
    h   = 1'b0;
    c   = 1'b0;
    case (op)
        3'd0, 3'd1: begin
            full = int'(a) + int'(b) + cin;
            low  = int'(a[3:0]) + int'(b[3:0]) + cin;
            h    = (low > 15);
            c    = (full > 255);
            res  = full[7:0];
        end
        3'd4:    res = a & b;
        3'd5:    res = a ^ b;
        3'd6:    res = a | b;
        default: begin                      // SUB, SBC and CP
            full = int'(a) - int'(b) - cin;
            low  = int'(a[3:0]) - int'(b[3:0]) - cin;
            n    = 1'b1;
            h    = (low < 0);
            c    = (full < 0);
            res  = full[7:0];
        end
    endcase
    return {res, res == 8'h00, n, h, c};
endfunction

// Flags held as {z, n, h, c}
function automatic logic cond_holds(input logic [1:0] cc, input logic [3:0] f);
    case (cc)
        2'd0:    return !f[3];
        2'd1:    return f[3];
        2'd2:    return !f[0];
        default: return f[0];
    endcase
endfunction

// Executes the image in mem and fills exp_addr, exp_data and exp_cycles
task automatic run_model(input logic [15:0] start);
    logic [7:0]  r [0:7];
    logic [3:0]  f;
    logic [15:0] pc;
    logic [7:0]  op;
    logic [7:0]  imm;
    logic [11:0] out;
    int          cyc_now;
    int          steps;
    logic        halted;
    for (int i = 0; i < 8; i++) begin
        r[i] = 8'h00;
    end
    f       = 4'h0;
    pc      = start;
    cyc_now = 1;                            // Cycle 0 runs the NOP left by reset
    steps   = 0;
    halted  = 1'b0;
    while (!halted && steps < 4096) begin
        op    = mem[pc[9:0]];
        imm   = mem[pc[9:0] + 10'd1];
        pc    = pc + 16'd1;
        steps = steps + 1;
        casez (op)
            8'h00: cyc_now += 1;
            8'h18, 8'b001??000: begin
                pc = pc + 16'd1;
                if (op == 8'h18 && imm == 8'hFE) begin
                    halted = 1'b1;          // JR to itself closes the program
                end else if (op == 8'h18 || cond_holds(op[4:3], f)) begin
                    pc      = pc + {{8{imm[7]}}, imm};
                    cyc_now += 3;
                end else begin
                    cyc_now += 2;
                end
            end
            8'hC3: begin
                pc      = {mem[pc[9:0] + 10'd1], imm};
                cyc_now += 4;
            end
            8'b00???110: begin
                r[op[5:3]] = imm;
                pc         = pc + 16'd1;
                cyc_now    += 2;
            end
            8'b00???10?: begin
                out        = alu_model(op[0] ? 3'd2 : 3'd0, r[op[5:3]], 8'h01, f[0]);
                r[op[5:3]] = out[11:4];
                f          = out[3:0];
                cyc_now    += 1;
            end
            8'b01110???: begin
                exp_addr.push_back({r[4], r[5]});
                exp_data.push_back(r[op[2:0]]);
                exp_cycles = cyc_now;
                cyc_now    += 2;
            end
            8'b01??????: begin
                r[op[5:3]] = r[op[2:0]];
                cyc_now    += 1;
            end
            8'b10??????, 8'b11???110: begin
                if (op[6]) begin
                    out     = alu_model(op[5:3], r[7], imm, f[0]);
                    pc      = pc + 16'd1;
                    cyc_now += 2;
                end else begin
                    out     = alu_model(op[5:3], r[7], r[op[2:0]], f[0]);
                    cyc_now += 1;
                end
                if (op[5:3] != 3'd7) begin
                    r[7] = out[11:4];       // CP leaves A alone
                end
                f = out[3:0];
            end
            default: cyc_now += 1;          // Never generated
        endcase
    end
endtask

`endif

//--- tb_sm83_core.sv
`timescale 1ns/1ps

module tb_sm83_core;

    localparam logic [15:0] RESET_PC = 16'h0040;
    localparam int          CLK_NS   = 20;
    localparam logic [7:0]  MARKER   = 8'h5A;
    localparam logic [15:0] PROG_END = 16'h0270;   // No block starts at or above this

    logic        clk;
    logic        rst;
    logic [7:0]  d_in;
    logic [15:0] addr;
    logic [7:0]  d_out;
    logic        write;

    logic [7:0]  mem [0:1023];
    logic [31:0] rng;
    logic [15:0] p;                 // Next free program byte
    int          n_instr;
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          exp_cycles;
    int          cyc        = 0;
    int          n_stores   = 0;
    int          final_cyc  = 0;
    logic        final_seen = 1'b0;
    logic        prev_write = 1'b0;
    int          checks;
    int          errors;
    int          tests;
    int          failed_tests;
    longint      wd_ns;

    `include "tb_sm83_model.svh"

    sm83_core #(.RESET_PC(RESET_PC)) sm83_core_i (
        .clk(clk), .rst(rst), .d_in(d_in), .addr(addr), .d_out(d_out), .write(write)
    );

    assign d_in = mem[addr[9:0]];   // Memory answers in the same cycle

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) begin
            failed_tests++;
            $display("Test %s: %0d error(s)", name, errors - errs_before);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift32(rng);
        return rng % n;
    endfunction

    task automatic put_byte(input logic [7:0] b);
        mem[p[9:0]] = b;
        p = p + 16'd1;
    endtask

    // Register field without (HL); H is kept at 0x03 unless allowed
    function automatic logic [2:0] pick_reg(input logic allow_h);
        logic [2:0] f;
        f = 3'(rand_below(7));
        if (f == 3'd6 || (!allow_h && f == 3'd4)) begin
            f = 3'd7;
        end
        return f;
    endfunction

    task automatic random_op();
        logic [2:0] dst;
        logic [2:0] src;
        logic [2:0] op;
        dst = pick_reg(1'b0);
        src = pick_reg(1'b1);
        op  = 3'(rand_below(8));
        n_instr++;
        case (rand_below(6))
            0: begin
                put_byte({2'b00, dst, 3'b110});             // LD r,n
                put_byte(8'(rand_below(256)));
            end
            1: put_byte({2'b01, dst, src});
            2: put_byte({2'b10, op, src});
            3: begin
                put_byte({2'b11, op, 3'b110});              // ALU A,n
                put_byte(8'(rand_below(256)));
            end
            4: put_byte({2'b00, dst, 2'b10, 1'(rand_below(2))});
            default: put_byte(8'h00);
        endcase
    endtask

    task automatic place_stores(input int k);
        repeat (k) begin
            put_byte({5'b01110, pick_reg(1'b1)});
            n_instr++;
        end
    endtask

    task automatic alu_block();
        repeat (2 + rand_below(7)) begin
            random_op();
        end
        place_stores(1 + rand_below(3));
    endtask

    // JR cc,e over a store and a JR past a pad
    task automatic forward_branch();
        int pad;
        pad = rand_below(100);
        put_byte({3'b001, 2'(rand_below(4)), 3'b000});
        put_byte(8'(3 + pad));
        place_stores(1);
        put_byte(8'h18);
        put_byte(8'(pad));
        p = p + 16'(pad);
        n_instr += 2;
    endtask

    // JR over a store, then JR cc,e back to it; the store leaves by a forward JR
    task automatic backward_branch();
        int pad1;
        int pad2;
        pad1 = rand_below(60);
        pad2 = rand_below(60);
        put_byte(8'h18);
        put_byte(8'(pad1 + 3 + pad2));
        p = p + 16'(pad1);
        place_stores(1);
        put_byte(8'h18);
        put_byte(8'(pad2 + 2));
        p = p + 16'(pad2);
        put_byte({3'b001, 2'(rand_below(4)), 3'b000});
        put_byte(8'(-(pad2 + 5)));
        n_instr += 3;
    endtask

    task automatic absolute_jump();
        logic [15:0] target;
        target = p + 16'd3 + 16'(rand_below(40));
        put_byte(8'hC3);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
        p = target;
        put_byte(8'h3E);                    // Block marker into A, then stored
        put_byte(8'(rand_below(256)));
        put_byte(8'h77);
        n_instr += 3;
    endtask

    task automatic build_program();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'(i ^ (i >> 3));
        end
        p       = RESET_PC;
        n_instr = 0;
        // Every register gets a value, H points stores at 0x300-0x3FF
        for (int i = 0; i < 8; i++) begin
            if (i != 6) begin
                put_byte({2'b00, 3'(i), 3'b110});
                put_byte((i == 4) ? 8'h03 : 8'(rand_below(256)));
                n_instr++;
            end
        end
        put_byte(8'hFE);                    // CP n sets the flags
        put_byte(8'(rand_below(256)));
        n_instr++;
        while (p < PROG_END) begin
            case (rand_below(5))
                0, 1: alu_block();
                2:    forward_branch();
                3:    backward_branch();
                default: absolute_jump();
            endcase
        end
        put_byte(8'h3E);
        put_byte(MARKER);
        put_byte(8'h77);
        put_byte(8'h18);                    // JR to itself
        put_byte(8'hFE);
        n_instr += 3;
    endtask

    // Memory commit and store checks
    always @(posedge clk) begin
        if (rst) begin
            if (write) begin
                mem[addr[9:0]] <= d_out;
                if (prev_write) begin
                    report_failure("write stayed high for two cycles in a row");
                end
                if (n_stores >= exp_addr.size()) begin
                    report_failure("the core wrote more often than the model expects");
                end else begin
                    check_value("addr", addr, exp_addr[n_stores]);
                    check_value("d_out", d_out, exp_data[n_stores]);
                    if (n_stores == exp_addr.size() - 1) begin
                        final_cyc  <= cyc;
                        final_seen <= 1'b1;
                    end
                end
                n_stores <= n_stores + 1;
            end
            prev_write <= write;
            cyc        <= cyc + 1;
        end
    end

    initial begin
        wait (wd_ns > 0);
        #(wd_ns);
        $display("Watchdog: the final marker store never appeared within %0d ns", wd_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int e0;
        rst          = 1'b0;
        rng          = 32'h7758;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        wd_ns        = 0;
        build_program();
        run_model(RESET_PC);
        $display("Program: %0d instructions, %0d stores, marker store in cycle %0d",
                 n_instr, exp_addr.size(), exp_cycles);
        wd_ns = longint'(16 + 4 * n_instr + 100) * CLK_NS;

        e0 = errors;
        repeat (16) begin
            @(posedge clk);
            check_value("write", write, 0);
            check_value("addr", addr, 0);
        end
        @(negedge clk);
        rst = 1'b1;
        @(posedge clk);
        check_value("addr", addr, RESET_PC);
        finish_test("reset", e0);

        e0 = errors;
        wait (final_seen);
        repeat (8) @(posedge clk);          // Any write after the marker is an error
        finish_test("stores", e0);

        e0 = errors;
        check_value("marker cycle", final_cyc, exp_cycles);
        finish_test("timing", e0);

        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
